/* common/grad_pkg.sv */
package grad_pkg;

    // ------------------------------------------------------------
    // frame geometry
    // ------------------------------------------------------------
    localparam int IMG_WIDTH  = 32;
    localparam int IMG_HEIGHT = 32;
    localparam int PIX_COUNT  = IMG_WIDTH * IMG_HEIGHT;

    // both memories share one index space
    localparam int ADDR_W = 10;

    // ------------------------------------------------------------
    // data types
    // ------------------------------------------------------------
    typedef logic [7:0]        pixel_t;
    typedef logic signed [9:0] diff_t;

    // gx in the upper half, gy in the lower half
    typedef logic [19:0]       grad_t;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [4:0]        col_t;

    // wishbone side
    typedef logic [1:0]        wb_addr_t;
    typedef logic [31:0]       wb_data_t;

    // register word offsets
    localparam wb_addr_t REG_CTRL   = 2'd0;
    localparam wb_addr_t REG_STATUS = 2'd1;

    // image read sequencer
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_FLUSH,
        FETCH_DONE
    } fetch_state_t;

endpackage

/* source/grad_regs.sv */
`timescale 1ns/1ps

module grad_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  grad_pkg::wb_addr_t wb_adr,
    input  grad_pkg::wb_data_t wb_dat_i,
    output grad_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack,
    output logic               start,
    input  logic               frame_done,
    output logic               done
);

    import grad_pkg::*;

    logic     req;
    logic     ctrl_wr;
    logic     start_ok;
    logic     busy;
    wb_data_t rd_data;

    // ------------------------------------------------------------
    // bus decode
    // ------------------------------------------------------------

    // new request only while no ack is out, so a held strobe acks once
    assign req     = wb_cyc & wb_stb & ~wb_ack;
    assign ctrl_wr = req & wb_we & (wb_adr == REG_CTRL);

    // start bit set and engine free
    assign start_ok = ctrl_wr & wb_dat_i[0] & ~busy;

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            REG_STATUS: begin
                rd_data[0] = busy;
                rd_data[1] = done;
            end
            // control reads back zero, start is self clearing
            default: rd_data = '0;
        endcase
    end

    // ------------------------------------------------------------
    // ack, start pulse and flags
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
        end else begin
            wb_ack <= req;
            // start lines up with the ack of the control write
            start  <= start_ok;
            if (start_ok) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (frame_done) begin
                busy <= 1'b0;
                // sticky until the next accepted start
                done <= 1'b1;
            end
        end
    end

    // read data captured with the request, valid with ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

/* grad_core/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    output logic            img_rd,
    output grad_pkg::addr_t img_addr,
    input  grad_pkg::pixel_t img_di,
    output logic            pix_valid,
    output logic            flush,
    output grad_pkg::pixel_t pix_data
);

    import grad_pkg::*;

    fetch_state_t state;
    col_t         flush_cnt;
    logic         rd_q;
    logic         flush_q;

    // one read per cycle for the whole READ state
    assign img_rd = (state == FETCH_READ);

    // ------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            img_addr  <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        state    <= FETCH_READ;
                        img_addr <= '0;
                    end
                end
                FETCH_READ: begin
                    if (img_addr == addr_t'(PIX_COUNT - 1)) begin
                        state     <= FETCH_FLUSH;
                        flush_cnt <= '0;
                    end else begin
                        img_addr <= img_addr + 1'b1;
                    end
                end
                FETCH_FLUSH: begin
                    // one row of dummy items pushes the last row out
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == col_t'(IMG_WIDTH - 1)) begin
                        state <= FETCH_DONE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // stream marking
    // ------------------------------------------------------------

    // memory answers one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q    <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            rd_q    <= img_rd;
            flush_q <= (state == FETCH_FLUSH);
        end
    end

    assign pix_valid = rd_q | flush_q;
    assign flush     = flush_q;
    assign pix_data  = flush_q ? '0 : img_di;

endmodule

/* grad_core/row_window.sv */
`timescale 1ns/1ps

module row_window (
    input  logic             clk,
    input  logic             reset,
    input  logic             pix_valid,
    input  logic             flush,
    input  grad_pkg::pixel_t pix_data,
    output logic             win_valid,
    output grad_pkg::addr_t  win_index,
    output grad_pkg::pixel_t win_center,
    output grad_pkg::pixel_t win_right,
    output grad_pkg::pixel_t win_below,
    output logic             last_col,
    output logic             last_row
);

    import grad_pkg::*;

    // line[0] holds the newest item, line[IMG_WIDTH-1] the item one row back
    pixel_t line [IMG_WIDTH];

    // column of the incoming item, row of the pixel leaving
    col_t col_cnt;
    col_t row_cnt;

    // first row seen, windows can leave
    logic primed;
    logic row_end;

    assign row_end = pix_valid & (col_cnt == col_t'(IMG_WIDTH - 1));

    // ------------------------------------------------------------
    // delay line
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line[0] <= pix_data;
            for (int k = 1; k < IMG_WIDTH; k++) begin
                line[k] <= line[k-1];
            end
        end
    end

    // ------------------------------------------------------------
    // position tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            col_cnt <= '0;
            row_cnt <= '0;
            primed  <= 1'b0;
        end else if (pix_valid) begin
            col_cnt <= col_cnt + 1'b1;
            if (row_end && primed) begin
                // square frame, row count wraps with the column count
                row_cnt <= row_cnt + 1'b1;
            end
            if (row_end && flush) begin
                // flush row done, frame fully drained
                primed <= 1'b0;
            end else if (row_end) begin
                primed <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // window output
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= pix_valid & primed;
        end
    end

    // incoming item is the lower neighbour of the oldest stored one
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            win_index  <= addr_t'({row_cnt, col_cnt});
            win_center <= line[IMG_WIDTH-1];
            win_right  <= line[IMG_WIDTH-2];
            win_below  <= pix_data;
            last_col   <= (col_cnt == col_t'(IMG_WIDTH - 1));
            last_row   <= flush;
        end
    end

endmodule

/* grad_core/grad_calc.sv */
`timescale 1ns/1ps

module grad_calc (
    input  logic             clk,
    input  logic             reset,
    input  logic             win_valid,
    input  logic             last_col,
    input  logic             last_row,
    input  grad_pkg::addr_t  win_index,
    input  grad_pkg::pixel_t win_center,
    input  grad_pkg::pixel_t win_right,
    input  grad_pkg::pixel_t win_below,
    output logic             grad_wr,
    output grad_pkg::addr_t  grad_addr,
    output grad_pkg::grad_t  grad_do,
    output logic             frame_done
);

    import grad_pkg::*;

    diff_t center_ext;
    diff_t right_ext;
    diff_t below_ext;
    diff_t gx;
    diff_t gy;

    // ------------------------------------------------------------
    // differences
    // ------------------------------------------------------------

    // zero extend, result spans -255..255
    assign center_ext = diff_t'({2'b00, win_center});
    assign right_ext  = diff_t'({2'b00, win_right});
    assign below_ext  = diff_t'({2'b00, win_below});

    always_comb begin
        gx = right_ext - center_ext;
        gy = below_ext - center_ext;
        // no neighbour past the frame edge
        if (last_col) begin
            gx = '0;
        end
        if (last_row) begin
            gy = '0;
        end
    end

    // ------------------------------------------------------------
    // write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            grad_addr <= win_index;
            grad_do   <= {gx, gy};
        end
    end

    // ------------------------------------------------------------
    // completion
    // ------------------------------------------------------------

    // one cycle after the last index is written
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= grad_wr & (grad_addr == addr_t'(PIX_COUNT - 1));
        end
    end

endmodule

/* source/grad_top.sv */
`timescale 1ns/1ps

module grad_top (
    input  logic               clk,
    input  logic               reset,
    // wishbone slave
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  grad_pkg::wb_addr_t wb_adr,
    input  grad_pkg::wb_data_t wb_dat_i,
    output grad_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack,
    // image memory read port
    output logic               img_rd,
    output grad_pkg::addr_t    img_addr,
    input  grad_pkg::pixel_t   img_di,
    // gradient memory write port
    output logic               grad_wr,
    output grad_pkg::addr_t    grad_addr,
    output grad_pkg::grad_t    grad_do,
    output logic               done
);

    import grad_pkg::*;

    logic   start;
    logic   frame_done;

    // pixel stream
    logic   pix_valid;
    logic   flush;
    pixel_t pix_data;

    // window to calc
    logic   win_valid;
    addr_t  win_index;
    pixel_t win_center;
    pixel_t win_right;
    pixel_t win_below;
    logic   last_col;
    logic   last_row;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    grad_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .start      (start),
        .frame_done (frame_done),
        .done       (done)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    pixel_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .flush     (flush),
        .pix_data  (pix_data)
    );

    row_window u_window (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .flush      (flush),
        .pix_data   (pix_data),
        .win_valid  (win_valid),
        .win_index  (win_index),
        .win_center (win_center),
        .win_right  (win_right),
        .win_below  (win_below),
        .last_col   (last_col),
        .last_row   (last_row)
    );

    grad_calc u_calc (
        .clk        (clk),
        .reset      (reset),
        .win_valid  (win_valid),
        .last_col   (last_col),
        .last_row   (last_row),
        .win_index  (win_index),
        .win_center (win_center),
        .win_right  (win_right),
        .win_below  (win_below),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .frame_done (frame_done)
    );

endmodule

/* verif/grad_checker.sv */
`timescale 1ns/1ps

module grad_checker (
    input  logic             clk,
    input  logic             reset,
    input  logic             img_rd,
    input  grad_pkg::addr_t  img_addr,
    input  logic             grad_wr,
    input  grad_pkg::addr_t  grad_addr,
    input  grad_pkg::grad_t  grad_do,
    input  logic             done,
    input  grad_pkg::pixel_t image [grad_pkg::PIX_COUNT],
    input  grad_pkg::grad_t  grad_mem [grad_pkg::PIX_COUNT]
);

    import grad_pkg::*;

    // start to done bound of the top level
    localparam int MAX_FRAME_CYCLES = PIX_COUNT + IMG_WIDTH + 8;

    string current_name = "none";
    logic  frame_active = 1'b0;
    logic  was_active   = 1'b0;
    logic  done_seen    = 1'b0;
    int    next_index;
    int    write_count;
    int    read_count;
    int    frame_cycles;

    // counted by the monitor
    int value_errors;
    int order_errors;
    int protocol_errors;
    int timing_errors;
    // counted by the tasks
    int frame_errors;
    int reg_errors;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic grad_t expected_word(input int idx);
        int row;
        int col;
        int center;
        int gx;
        int gy;
        row    = idx / IMG_WIDTH;
        col    = idx % IMG_WIDTH;
        center = int'(image[idx]);
        gx     = 0;
        gy     = 0;
        // no neighbour past the right or lower edge
        if (col != IMG_WIDTH - 1) begin
            gx = int'(image[idx + 1]) - center;
        end
        if (row != IMG_HEIGHT - 1) begin
            gy = int'(image[idx + IMG_WIDTH]) - center;
        end
        return {gx[9:0], gy[9:0]};
    endfunction

    // ------------------------------------------------------------
    // control from the testbench
    // ------------------------------------------------------------
    task automatic select_test(input string name);
        current_name = name;
    endtask

    task automatic begin_frame();
        frame_active = 1'b1;
    endtask

    task automatic end_frame();
        grad_t expected;
        frame_active = 1'b0;
        if (write_count != PIX_COUNT) begin
            frame_errors++;
            $display("[ERROR] test %s: gradient write count expected %0d actual %0d",
                     current_name, PIX_COUNT, write_count);
        end
        if (read_count != PIX_COUNT) begin
            frame_errors++;
            $display("[ERROR] test %s: image read count expected %0d actual %0d",
                     current_name, PIX_COUNT, read_count);
        end
        if (!done_seen) begin
            frame_errors++;
            $display("test %s: frame ended but the done output never rose", current_name);
        end
        // memory contents left behind by the frame
        for (int i = 0; i < PIX_COUNT; i++) begin
            expected = expected_word(i);
            if (grad_mem[i] !== expected) begin
                frame_errors++;
                $display("[ERROR] test %s: stored gradient %0d expected %05h actual %05h",
                         current_name, i, expected, grad_mem[i]);
            end
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            reg_errors++;
            $display("[ERROR] test %s: %s expected %h actual %h",
                     current_name, what, expected, actual);
        end
    endtask

    function automatic int error_total();
        return value_errors + order_errors + protocol_errors + timing_errors
               + frame_errors + reg_errors;
    endfunction

    task automatic report_counts();
        $display("errors: value %0d, order %0d, frame %0d, protocol %0d, timing %0d, %s %0d",
                 value_errors, order_errors, frame_errors, protocol_errors,
                 timing_errors, "register", reg_errors);
    endtask

    // ------------------------------------------------------------
    // write port monitor
    // ------------------------------------------------------------
    always @(posedge clk) begin : monitor
        grad_t expected;
        int    idx;
        if (!reset) begin
            if (frame_active && !was_active) begin
                next_index   = 0;
                write_count  = 0;
                read_count   = 0;
                frame_cycles = 1;
                done_seen    = 1'b0;
            end else if (frame_active && !done_seen) begin
                if (done) begin
                    done_seen = 1'b1;
                    if (frame_cycles > MAX_FRAME_CYCLES) begin
                        timing_errors++;
                        $display("test %s: frame took %0d cycles to done, limit is %0d",
                                 current_name, frame_cycles, MAX_FRAME_CYCLES);
                    end
                end else begin
                    frame_cycles++;
                end
            end
            was_active = frame_active;

            if (img_rd) begin
                if (!frame_active) begin
                    protocol_errors++;
                    $display("image memory read while no frame is running");
                end else begin
                    // raster order, one address per read
                    if (int'(img_addr) != read_count) begin
                        order_errors++;
                        $display("[ERROR] test %s: image read address expected %0d actual %0d",
                                 current_name, read_count, img_addr);
                    end
                    read_count++;
                end
            end

            if (grad_wr) begin
                idx = int'(grad_addr);
                if (!frame_active) begin
                    protocol_errors++;
                    $display("gradient write to index %0d while no frame is running", idx);
                end else begin
                    if (idx != next_index) begin
                        order_errors++;
                        $display("[ERROR] test %s: write index expected %0d actual %0d",
                                 current_name, next_index, idx);
                    end
                    next_index = idx + 1;
                    write_count++;
                    expected = expected_word(idx);
                    if (grad_do !== expected) begin
                        value_errors++;
                        $display("[ERROR] test %s: gradient %0d expected %05h actual %05h",
                                 current_name, idx, expected, grad_do);
                    end
                end
            end
        end
    end

endmodule

/* verif/tb_grad.sv */
`timescale 1ns/1ps

module tb_grad;

    import grad_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (PIX_COUNT + IMG_WIDTH + TIMEOUT_MARGIN);

    localparam logic [15:0] LFSR_SEED = 16'd80;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    // pattern kinds
    localparam int PAT_CONST   = 0;
    localparam int PAT_HRAMP   = 1;
    localparam int PAT_VRAMP   = 2;
    localparam int PAT_CHECKER = 3;
    localparam int PAT_RANDOM  = 4;

    logic     clk;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_i;
    wb_data_t wb_dat_o;
    logic     wb_ack;
    logic     img_rd;
    addr_t    img_addr;
    pixel_t   img_di;
    logic     grad_wr;
    addr_t    grad_addr;
    grad_t    grad_do;
    logic     done;

    pixel_t      image_mem [PIX_COUNT];
    grad_t       grad_mem [PIX_COUNT];
    addr_t       rd_addr;
    logic [15:0] lfsr_state;
    int          cycle_count = 0;

    string test_name [NUM_TESTS];
    int    test_kind [NUM_TESTS];

    grad_top DUT (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    grad_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done),
        .image     (image_mem),
        .grad_mem  (grad_mem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // memory models
    // ------------------------------------------------------------

    // one cycle read latency
    always @(posedge clk) begin
        if (img_rd) begin
            rd_addr = img_addr;
            #(DRIVE_DELAY);
            img_di = image_mem[rd_addr];
        end
    end

    always @(posedge clk) begin
        if (grad_wr) begin
            grad_mem[grad_addr] <= grad_do;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // wishbone master
    // ------------------------------------------------------------
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        @(posedge clk);
        #(DRIVE_DELAY);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        // hold until ack
        do begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end while (!wb_ack);
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdata);
        wb_data_t discard;
        wb_access(1'b1, adr, wdata, discard);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdata);
        wb_access(1'b0, adr, '0, rdata);
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    task automatic next_random_byte(output pixel_t value);
        pixel_t bits;
        bits = '0;
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[6:0], lfsr_state[0]};
        end
        value = bits;
    endtask

    task automatic load_table();
        test_name[0] = "constant_77";
        test_kind[0] = PAT_CONST;
        test_name[1] = "h_ramp";
        test_kind[1] = PAT_HRAMP;
        test_name[2] = "v_ramp";
        test_kind[2] = PAT_VRAMP;
        test_name[3] = "checkerboard";
        test_kind[3] = PAT_CHECKER;
        test_name[4] = "lfsr_random";
        test_kind[4] = PAT_RANDOM;
    endtask

    task automatic fill_image(input int kind);
        int     row;
        int     col;
        int     value;
        pixel_t rnd;
        for (int i = 0; i < PIX_COUNT; i++) begin
            row = i / IMG_WIDTH;
            col = i % IMG_WIDTH;
            case (kind)
                PAT_CONST:   value = 77;
                PAT_HRAMP:   value = col * 8;
                PAT_VRAMP:   value = row * 8;
                // neighbours differ by the full range
                PAT_CHECKER: value = ((row + col) % 2 == 1) ? 255 : 0;
                default: begin
                    next_random_byte(rnd);
                    value = int'(rnd);
                end
            endcase
            image_mem[i] = pixel_t'(value);
        end
    endtask

    task automatic check_undefined_offsets();
        wb_data_t value;
        wb_read(2'd2, value);
        u_checker.compare_word("read of offset 2", 32'h0, value);
        wb_read(2'd3, value);
        u_checker.compare_word("read of offset 3", 32'h0, value);
    endtask

    task automatic run_frame();
        wb_data_t status;
        wb_write(REG_CTRL, 32'h1);
        u_checker.begin_frame();
        wb_read(REG_STATUS, status);
        u_checker.compare_word("status while running", 32'h1, status);
        // a second start while busy
        wb_write(REG_CTRL, 32'h1);
        status = '0;
        while (!status[1]) begin
            wb_read(REG_STATUS, status);
        end
        u_checker.compare_word("status after frame", 32'h2, status);
        u_checker.compare_word("done output after frame", 32'h1, 32'(done));
        u_checker.end_frame();
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        wb_data_t value;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        img_di     = '0;
        lfsr_state = LFSR_SEED;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        u_checker.select_test("after_reset");
        u_checker.compare_word("ack after reset", 32'h0, 32'(wb_ack));
        u_checker.compare_word("done output after reset", 32'h0, 32'(done));
        wb_read(REG_STATUS, value);
        u_checker.compare_word("status after reset", 32'h0, value);
        check_undefined_offsets();

        for (int t = 0; t < NUM_TESTS; t++) begin
            u_checker.select_test(test_name[t]);
            fill_image(test_kind[t]);
            run_frame();
            check_undefined_offsets();
        end

        // quiet tail for stray writes
        repeat (IMG_WIDTH) @(posedge clk);
        u_checker.report_counts();
        if (u_checker.error_total() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/grad_pkg.sv
source/grad_regs.sv
grad_core/pixel_fetch.sv
grad_core/row_window.sv
grad_core/grad_calc.sv
source/grad_top.sv
verif/grad_checker.sv
verif/tb_grad.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_grad -f vlog.f -o tb_grad_sim

sim_out=$(./obj_dir/tb_grad_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
